// File: rtl/rv32_branch.sv
`timescale 1ns/1ps

module rv32_branch (
    input  rv32_branch_pkg::branch_op_t op,
    input  logic [31:0]                 result,
    output logic                        taken
);
    import rv32_branch_pkg::*;

    logic result_zero;

    assign result_zero = (result == 32'd0);

    always_comb begin
        case (op)
            BRANCH_NEVER:    taken = 1'b0;
            BRANCH_ZERO:     taken = result_zero;
            BRANCH_NON_ZERO: taken = !result_zero;
            BRANCH_ALWAYS:   taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

endmodule

// File: rtl/rv32_branch_pkg.sv
package rv32_branch_pkg;

    // Branch decision against a zero test of the execute result
    typedef enum logic [1:0] {
        BRANCH_NEVER    = 2'b00,
        BRANCH_ZERO     = 2'b01,
        BRANCH_NON_ZERO = 2'b10,
        BRANCH_ALWAYS   = 2'b11
    } branch_op_t;

endpackage

// File: rtl/rv32_data_ram.sv
`timescale 1ns/1ps

module rv32_data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic        clk,
    input  logic [31:0] addr,
    input  logic [31:0] write_value,
    input  logic [3:0]  write_mask,
    output logic [31:0] read_value
);
    localparam int INDEX_BITS = $clog2(RAM_WORDS);

    logic [31:0]           mem [RAM_WORDS];
    logic [INDEX_BITS-1:0] index;

    // Upper address bits wrap onto the array
    assign index = addr[INDEX_BITS+1:2];

    assign read_value = mem[index];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (write_mask[i]) begin
                mem[index][8*i +: 8] <= write_value[8*i +: 8];
            end
        end
    end

endmodule

// File: rtl/rv32_ex_mem_reg.sv
`timescale 1ns/1ps

module rv32_ex_mem_reg (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  rv32_mem_pkg::ex_mem_t issue,
    output rv32_mem_pkg::ex_mem_t ex_mem
);
    import rv32_mem_pkg::*;
    import rv32_branch_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.read      <= 1'b0;
            ex_mem.write     <= 1'b0;
            ex_mem.rd_write  <= 1'b0;
            ex_mem.branch_op <= BRANCH_NEVER;
        end else if (!stall) begin
            ex_mem <= issue;
        end
    end

    // Memory records must carry one of the three legal widths
    width_legal_a: assert property (
        @(posedge clk) disable iff (reset)
        (ex_mem.read || ex_mem.write) |-> (ex_mem.width != 2'b11)
    );

endmodule

// File: rtl/rv32_mem.sv
`timescale 1ns/1ps

module rv32_mem (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  rv32_mem_pkg::ex_mem_t ex_mem,
    input  logic [31:0]           mem_read_value,
    output logic [31:0]           mem_addr,
    output logic [31:0]           mem_write_value,
    output logic [3:0]            mem_write_mask,
    output logic                  branch_taken,
    output logic [31:0]           branch_pc,
    output rv32_mem_pkg::mem_wb_t wb
);
    import rv32_mem_pkg::*;

    logic [1:0]  offset;
    logic [15:0] load_half;
    logic [7:0]  load_byte;
    logic [31:0] load_value;

    rv32_branch branch_i (
        .op     (ex_mem.branch_op),
        .result (ex_mem.result),
        .taken  (branch_taken)
    );

    assign branch_pc = ex_mem.branch_pc;
    assign mem_addr  = ex_mem.result;
    assign offset    = ex_mem.result[1:0];

    // Offset 0 is the top lane and mask bit 3 covers bits 31:24
    always_comb begin
        mem_write_value = ex_mem.rs2_value;
        mem_write_mask  = 4'b0000;
        if (ex_mem.write) begin
            case (ex_mem.width)
                MEM_WIDTH_WORD: begin
                    mem_write_mask = 4'b1111;
                end
                MEM_WIDTH_HALF: begin
                    mem_write_value = {2{ex_mem.rs2_value[15:0]}};
                    mem_write_mask  = offset[1] ? 4'b0011 : 4'b1100;
                end
                MEM_WIDTH_BYTE: begin
                    mem_write_value = {4{ex_mem.rs2_value[7:0]}};
                    mem_write_mask  = 4'b1000 >> offset;
                end
                default: begin
                    mem_write_mask = 4'b0000;
                end
            endcase
        end
    end

    assign load_half = offset[1] ? mem_read_value[15:0] : mem_read_value[31:16];

    always_comb begin
        case (offset)
            2'b00:   load_byte = mem_read_value[31:24];
            2'b01:   load_byte = mem_read_value[23:16];
            2'b10:   load_byte = mem_read_value[15:8];
            default: load_byte = mem_read_value[7:0];
        endcase
    end

    always_comb begin
        case (ex_mem.width)
            MEM_WIDTH_HALF: begin
                load_value = {{16{!ex_mem.zero_extend && load_half[15]}}, load_half};
            end
            MEM_WIDTH_BYTE: begin
                load_value = {{24{!ex_mem.zero_extend && load_byte[7]}}, load_byte};
            end
            default: begin
                load_value = mem_read_value;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.rd_write <= 1'b0;
        end else if (!stall) begin
            wb.rd       <= ex_mem.rd;
            wb.rd_write <= ex_mem.rd_write && !flush; // Flushed record still stores
            wb.rd_value <= ex_mem.read ? load_value : ex_mem.result;
        end
    end

    half_aligned_a: assert property (
        @(posedge clk) disable iff (reset)
        ((ex_mem.read || ex_mem.write) && ex_mem.width == MEM_WIDTH_HALF)
            |-> !ex_mem.result[0]
    );

    word_aligned_a: assert property (
        @(posedge clk) disable iff (reset)
        ((ex_mem.read || ex_mem.write) && ex_mem.width == MEM_WIDTH_WORD)
            |-> (ex_mem.result[1:0] == 2'b00)
    );

    // A single record is either a load or a store
    read_write_excl_a: assert property (
        @(posedge clk) disable iff (reset)
        !(ex_mem.read && ex_mem.write)
    );

endmodule

// File: rtl/rv32_mem_pkg.sv
package rv32_mem_pkg;

    import rv32_branch_pkg::*;

    // Access width of a load or store
    // The code 2'b11 is never issued
    typedef enum logic [1:0] {
        MEM_WIDTH_WORD = 2'b00,
        MEM_WIDTH_HALF = 2'b01,
        MEM_WIDTH_BYTE = 2'b10
    } mem_width_t;

    // One instruction as it leaves execute
    typedef struct packed {
        logic       read;
        logic       write;
        mem_width_t width;
        logic       zero_extend;  // Zero- instead of sign-extend on loads
        branch_op_t branch_op;
        logic [4:0] rd;
        logic       rd_write;
        logic [31:0] result;      // ALU result and also the address
        logic [31:0] rs2_value;   // Store data
        logic [31:0] branch_pc;
    } ex_mem_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        rd_write;
        logic [31:0] rd_value;
    } mem_wb_t;

endpackage

// File: rtl/rv32_mem_unit.sv
`timescale 1ns/1ps

module rv32_mem_unit #(
    parameter int RAM_WORDS = 256  // Power of two
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  rv32_mem_pkg::ex_mem_t issue,
    output rv32_mem_pkg::mem_wb_t wb,
    output logic                  branch_taken,
    output logic [31:0]           branch_pc
);
    import rv32_mem_pkg::*;

    ex_mem_t     ex_mem;
    logic [31:0] mem_addr;
    logic [31:0] mem_write_value;
    logic [3:0]  mem_write_mask;
    logic [31:0] mem_read_value;

    rv32_ex_mem_reg ex_mem_reg_i (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .issue  (issue),
        .ex_mem (ex_mem)
    );

    rv32_mem mem_i (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .flush           (flush),
        .ex_mem          (ex_mem),
        .mem_read_value  (mem_read_value),
        .mem_addr        (mem_addr),
        .mem_write_value (mem_write_value),
        .mem_write_mask  (mem_write_mask),
        .branch_taken    (branch_taken),
        .branch_pc       (branch_pc),
        .wb              (wb)
    );

    rv32_data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) data_ram_i (
        .clk         (clk),
        .addr        (mem_addr),
        .write_value (mem_write_value),
        .write_mask  (mem_write_mask),
        .read_value  (mem_read_value)
    );

endmodule

// File: rv32_mem_unit.f
rtl/rv32_branch_pkg.sv
rtl/rv32_mem_pkg.sv
rtl/rv32_branch.sv
rtl/rv32_ex_mem_reg.sv
rtl/rv32_mem.sv
rtl/rv32_data_ram.sv
rtl/rv32_mem_unit.sv
verif/rv32_mem_unit_tb.sv

// File: verif/rv32_mem_unit_tb.sv
`timescale 1ns/1ps

module rv32_mem_unit_tb;
    import rv32_mem_pkg::*;
    import rv32_branch_pkg::*;

    localparam int RAM_WORDS    = 256;
    localparam int RAM_BYTES    = RAM_WORDS * 4;
    localparam int FILL_WORDS   = 32;  // Random accesses stay inside this region
    localparam int RANDOM_COUNT = 400;
    localparam int TOTAL_ISSUES = 2 * FILL_WORDS + RANDOM_COUNT + 2;
    localparam int CYCLE_LIMIT  = 2 * TOTAL_ISSUES + 100;

    // Expected DUT state after one clock edge
    typedef struct packed {
        logic        wb_valid;
        mem_wb_t     wb;
        logic        stage_valid;
        logic        taken;
        logic [31:0] branch_pc;
    } edge_expect_t;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    ex_mem_t     issue;
    mem_wb_t     wb;
    logic        branch_taken;
    logic [31:0] branch_pc;

    logic [7:0]   ref_mem [RAM_BYTES];  // Byte 0 of a word is bits 31:24
    ex_mem_t      stage_rec;
    logic         stage_valid = 1'b0;
    mem_wb_t      exp_wb = '0;
    logic         wb_valid = 1'b0;
    edge_expect_t exp_q[$];
    string        name_q[$];
    string        test_name = "reset";
    logic [31:0]  lfsr_state = 32'h7175_1aae;
    int           mismatch_count = 0;
    int           other_count = 0;
    int           edges_pushed = 0;
    int           edges_checked = 0;
    int           cycle_count = 0;

    rv32_mem_unit #(
        .RAM_WORDS (RAM_WORDS)
    ) rv32_mem_unit_i (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .flush        (flush),
        .issue        (issue),
        .wb           (wb),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic expected_taken(input ex_mem_t rec);
        case (rec.branch_op)
            BRANCH_ZERO:     return rec.result == 32'd0;
            BRANCH_NON_ZERO: return rec.result != 32'd0;
            BRANCH_ALWAYS:   return 1'b1;
            default:         return 1'b0;
        endcase
    endfunction

    function automatic mem_wb_t expected_wb(input ex_mem_t rec, input logic flushed);
        mem_wb_t r;
        int      a;
        logic    sign;
        a = rec.result % RAM_BYTES;
        r.rd = rec.rd;
        r.rd_write = rec.rd_write && !flushed;
        r.rd_value = rec.result;
        sign = !rec.zero_extend && ref_mem[a][7];  // Top byte of the addressed lane
        if (rec.read) begin
            case (rec.width)
                MEM_WIDTH_WORD: r.rd_value = {ref_mem[a], ref_mem[a+1], ref_mem[a+2], ref_mem[a+3]};
                MEM_WIDTH_HALF: r.rd_value = {{16{sign}}, ref_mem[a], ref_mem[a+1]};
                default:        r.rd_value = {{24{sign}}, ref_mem[a]};
            endcase
        end
        return r;
    endfunction

    task automatic apply_store(input ex_mem_t rec);
        int a;
        a = rec.result % RAM_BYTES;
        case (rec.width)
            MEM_WIDTH_WORD: begin
                {ref_mem[a], ref_mem[a+1], ref_mem[a+2], ref_mem[a+3]} = rec.rs2_value;
            end
            MEM_WIDTH_HALF: {ref_mem[a], ref_mem[a+1]} = rec.rs2_value[15:0];
            default:        ref_mem[a] = rec.rs2_value[7:0];
        endcase
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Drives one cycle at the falling edge and models the rising edge that follows
    task automatic drive_cycle(input ex_mem_t rec, input logic st, input logic fl);
        edge_expect_t e;
        issue = rec;
        stall = st;
        flush = fl;
        if (!st && stage_valid) begin
            exp_wb = expected_wb(stage_rec, fl);
            wb_valid = 1'b1;
        end
        if (stage_valid && stage_rec.write) apply_store(stage_rec);  // Repeats while stalled
        if (!st) begin
            stage_rec = rec;
            stage_valid = 1'b1;
        end
        e.wb_valid = wb_valid;
        e.wb = exp_wb;
        e.stage_valid = stage_valid;
        e.taken = stage_valid ? expected_taken(stage_rec) : 1'b0;
        e.branch_pc = stage_rec.branch_pc;
        exp_q.push_back(e);
        name_q.push_back(test_name);
        edges_pushed++;
        @(negedge clk);
    endtask

    task automatic make_random_record(output ex_mem_t rec);
        logic [1:0] kind;
        logic [1:0] w;
        logic [1:0] op;
        rec = '0;
        kind = random_bits(2);
        w = random_bits(2);
        op = random_bits(2);
        rec.width = (w == 2'b11) ? MEM_WIDTH_BYTE : mem_width_t'(w);
        rec.branch_op = branch_op_t'(op);
        rec.zero_extend = random_bits(1);
        rec.rd = random_bits(5);
        rec.rd_write = random_bits(1);
        rec.rs2_value = random_bits(32);
        rec.branch_pc = random_bits(32);
        rec.read = (kind == 2'd0);
        rec.write = (kind == 2'd1);
        if (kind[1]) begin
            rec.result = random_bits(32);
            if (random_bits(2) == 0) rec.result = 32'd0;  // Exercise the zero test
        end else begin
            rec.result = random_bits(5) << 2;
            if (rec.width == MEM_WIDTH_HALF) rec.result[1] = random_bits(1);
            if (rec.width == MEM_WIDTH_BYTE) rec.result[1:0] = random_bits(2);
        end
    endtask

    initial begin
        ex_mem_t rec;
        logic    st;
        logic    fl;
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        issue = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_value("reset wb.rd_write", 1'b0, wb.rd_write);
        check_value("reset branch_taken", 1'b0, branch_taken);

        test_name = "word_fill";
        for (int w = 0; w < FILL_WORDS; w++) begin
            rec = '0;
            rec.write = 1'b1;
            rec.width = MEM_WIDTH_WORD;
            rec.result = w * 4;
            rec.rs2_value = random_bits(32);
            drive_cycle(rec, 1'b0, 1'b0);
        end

        test_name = "word_readback";
        for (int w = 0; w < FILL_WORDS; w++) begin
            rec = '0;
            rec.read = 1'b1;
            rec.width = MEM_WIDTH_WORD;
            rec.rd = w[4:0];
            rec.rd_write = 1'b1;
            rec.result = w * 4;
            drive_cycle(rec, 1'b0, 1'b0);
        end

        test_name = "random";
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            make_random_record(rec);
            st = (random_bits(3) == 0);
            fl = (random_bits(3) == 0);
            drive_cycle(rec, st, fl);
        end

        test_name = "drain";
        repeat (2) drive_cycle(ex_mem_t'('0), 1'b0, 1'b0);

        wait (edges_checked == edges_pushed);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Compares outputs at the falling edge after each rising edge
    initial begin
        edge_expect_t e;
        string        name;
        forever begin
            @(posedge clk);
            if (!reset) begin
                if (exp_q.size() == 0) begin
                    other_count++;
                    $display("Checker found no expected values for the clock edge at %0t", $time);
                end else begin
                    e = exp_q.pop_front();
                    name = name_q.pop_front();
                    @(negedge clk);
                    if (e.wb_valid) check_value({name, " wb"}, e.wb, wb);
                    else check_value({name, " wb.rd_write"}, e.wb.rd_write, wb.rd_write);
                    check_value({name, " branch_taken"}, e.taken, branch_taken);
                    if (e.stage_valid) check_value({name, " branch_pc"}, e.branch_pc, branch_pc);
                    edges_checked++;
                end
            end
        end
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d of %0d edges checked, %0d mismatches",
                 CYCLE_LIMIT, edges_checked, edges_pushed, mismatch_count);
        $display("TEST FAIL");
        $finish;
    end

endmodule
